// File: dv/tb_status_tasks.svh
`ifndef TB_STATUS_TASKS_SVH
`define TB_STATUS_TASKS_SVH

    // model flags as seen on the port
    function automatic status_word_t psr_view();
        status_word_t v;
        v = exp_psr;
        v[`PSR_B] = brk; // break pin on 5:4
        v[`PSR_U] = brk;
        return v;
    endfunction

    task automatic check_byte(input string name, input logic [7:0] exp, input logic [7:0] act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("Fail %s result: expected %02h actual %02h", name, exp, act);
        end
    endtask

    task automatic check_psr(input string name, input status_word_t exp,
                             input status_word_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("Fail %s psr: expected %08b actual %08b", name, exp, act);
        end
    endtask

    task automatic check_count(input string name, input int exp, input int act);
        checks++;
        if (act != exp) begin
            errors++;
            $display("Fail %s exec pulses: expected %0d actual %0d", name, exp, act);
        end
    endtask

    // one four-phase transfer, hold keeps req up after ack
    task automatic run_op(input string name, input exec_op_e o, input logic [7:0] a,
                          input logic [7:0] b, input int hold);
        logic [7:0]   exp_res;
        logic [7:0]   res_seen;
        status_word_t psr_seen;
        int           waited;
        int           exec_before;
        model_step(o, a, b, exp_res);
        exec_before = exec_count;
        @(posedge clk);
        #1;
        op     = o;
        opnd_a = a;
        opnd_b = b;
        req    = 1'b1;
        waited = 0;
        while (ack !== 1'b1 && waited < `EXEC_ACK_TIMEOUT) begin
            @(posedge clk);
            #1;
            waited++;
        end
        if (ack !== 1'b1) begin
            errors++;
            $display("error: %s got no ack within %0d cycles", name, `EXEC_ACK_TIMEOUT);
        end
        res_seen = result;
        psr_seen = psr;
        check_byte(name, exp_res, result);
        check_psr(name, psr_view(), psr);
        repeat (hold) begin
            @(posedge clk);
            #1;
            if (ack !== 1'b1 || result !== res_seen || psr !== psr_seen) begin
                errors++;
                $display("error: %s ack or outputs moved while req was held", name);
            end
        end
        req    = 1'b0;
        waited = 0;
        while (ack !== 1'b0 && waited < `EXEC_ACK_TIMEOUT) begin
            @(posedge clk);
            #1;
            waited++;
        end
        if (ack !== 1'b0) begin
            errors++;
            $display("error: %s ack stayed high after req fell", name);
        end
        check_count(name, exec_before + 1, exec_count); // exactly one execute
    endtask

    task automatic report_test(input string name, input int err0);
        tests_run++;
        if (errors == err0) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: %0d errors", name, errors - err0);
        end
    endtask

    task automatic test_flags();
        int err0;
        err0 = errors;
        check_psr("flags", psr_view(), psr); // reset value, only brk bits
        check_byte("flags", 8'h00, result);
        run_op("flags", OP_SEC, 8'h00, 8'h00, 0);
        run_op("flags", OP_CLC, 8'h00, 8'h00, 0);
        run_op("flags", OP_SEI, 8'h00, 8'h00, 0);
        run_op("flags", OP_CLI, 8'h00, 8'h00, 0);
        run_op("flags", OP_SED, 8'h00, 8'h00, 0);
        run_op("flags", OP_CLD, 8'h00, 8'h00, 0);
        run_op("flags", OP_SEV, 8'h00, 8'h00, 0);
        run_op("flags", OP_CLV, 8'h00, 8'h00, 0);
        report_test("flags", err0);
    endtask

    task automatic test_adc();
        int          err0;
        logic [31:0] rnd;
        err0 = errors;
        run_op("adc", OP_SEI, 8'h00, 8'h00, 0); // i and d must survive the adds
        run_op("adc", OP_SED, 8'h00, 8'h00, 0);
        repeat (N_ADC) begin
            rnd = $urandom();
            run_op("adc", OP_ADC, rnd[7:0], rnd[15:8], 0);
        end
        report_test("adc", err0);
    endtask

    task automatic test_sub();
        int          err0;
        logic [31:0] rnd;
        err0 = errors;
        for (int i = 0; i < N_SUB; i++) begin
            rnd = $urandom();
            run_op("sub", OP_SBC, rnd[7:0], rnd[15:8], 0);
            run_op("sub", OP_CMP, rnd[23:16], (i == 0) ? rnd[23:16] : rnd[31:24], 0);
        end
        report_test("sub", err0);
    endtask

    task automatic test_logic();
        int          err0;
        logic [31:0] rnd;
        err0 = errors;
        run_op("logic", OP_SEC, 8'h00, 8'h00, 0); // c and v must hold
        run_op("logic", OP_SEV, 8'h00, 8'h00, 0);
        for (int i = 0; i < N_LOGIC; i++) begin
            rnd = $urandom();
            if (i == 0) begin
                rnd[15:0] = 16'h0000; // all four give zero
            end else if (i == 1) begin
                rnd[15:8] = ~rnd[7:0]; // and gives zero
            end
            run_op("logic", OP_AND, rnd[7:0], rnd[15:8], 0);
            run_op("logic", OP_ORA, rnd[7:0], rnd[15:8], 0);
            run_op("logic", OP_EOR, rnd[7:0], (i == 0) ? rnd[7:0] : rnd[15:8], 0);
            run_op("logic", OP_LDA, rnd[7:0], rnd[15:8], 0);
        end
        report_test("logic", err0);
    endtask

    task automatic test_plp();
        int          err0;
        logic [31:0] rnd;
        err0 = errors;
        run_op("plp", OP_PLP, 8'h00, 8'hff, 0);
        run_op("plp", OP_PLP, 8'h00, 8'h00, 0);
        repeat (N_PLP) begin
            rnd = $urandom();
            brk = ~brk;
            @(negedge clk);
            check_psr("plp", psr_view(), psr); // 5:4 follow brk without a clock
            run_op("plp", OP_PLP, rnd[15:8], rnd[7:0], 0);
        end
        brk = 1'b0;
        report_test("plp", err0);
    endtask

    task automatic test_backpressure();
        int          err0;
        logic [31:0] rnd;
        err0 = errors;
        rnd  = $urandom();
        run_op("backpressure", OP_ADC, rnd[7:0], rnd[15:8], 10); // req held 10 cycles
        run_op("backpressure", OP_ADC, rnd[23:16], rnd[31:24], 0);
        report_test("backpressure", err0);
    endtask

`endif

// File: dv/tb_status_exec.sv
`timescale 1ns/1ps
`default_nettype none
`include "status_defs.svh"

module tb_status_exec
    import status_pkg::*;
();

    localparam int N_ADC   = 50;
    localparam int N_SUB   = 25; // sbc and cmp per round
    localparam int N_LOGIC = 6;  // rounds over and/ora/eor/lda
    localparam int N_PLP   = 16;
    localparam int NUM_OPS = 8 + (2 + N_ADC) + 2 * N_SUB + (2 + 4 * N_LOGIC) + (2 + N_PLP) + 2;
    localparam int RUN_LIMIT = NUM_OPS * `EXEC_CYC_PER_OP + `EXEC_TIMEOUT_BASE;

    logic         clk;
    logic         nrst;
    logic         req;
    logic         brk;
    logic         ack;
    exec_op_e     op;
    logic [7:0]   opnd_a;
    logic [7:0]   opnd_b;
    logic [7:0]   result;
    status_word_t psr;

    status_word_t exp_psr = 8'h00; // model flags, bits 5:4 always clear
    int errors     = 0;
    int checks     = 0;
    int tests_run  = 0;
    int exec_count = 0; // execute pulses seen

    status_exec_top dut0 (
        .clk(clk), .nrst(nrst), .req(req), .op(op),
        .opnd_a(opnd_a), .opnd_b(opnd_b), .brk(brk),
        .ack(ack), .result(result), .psr(psr)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk; // 10 ns period
    end

    always @(negedge clk) begin
        if (dut0.exec) begin
            exec_count++; // sampled mid cycle
        end
    end

    // 6502 binary rules, worked on ints
    task automatic model_step(input exec_op_e o, input logic [7:0] a, input logic [7:0] b,
                              output logic [7:0] r);
        int borrow;
        int u_r; // unsigned view
        int s_r; // signed view, for v
        borrow = exp_psr[`PSR_C] ? 0 : 1;
        u_r    = int'(b); // pass of b unless noted
        s_r    = 0;
        case (o)
            OP_ADC: begin
                u_r = int'(a) + int'(b) + 1 - borrow;
                s_r = int'($signed(a)) + int'($signed(b)) + 1 - borrow;
                exp_psr[`PSR_C] = (u_r > 255);
                exp_psr[`PSR_V] = (s_r > 127) || (s_r < -128);
            end
            OP_SBC: begin
                u_r = int'(a) - int'(b) - borrow;
                s_r = int'($signed(a)) - int'($signed(b)) - borrow;
                exp_psr[`PSR_C] = (u_r >= 0); // c set when no borrow
                exp_psr[`PSR_V] = (s_r > 127) || (s_r < -128);
            end
            OP_CMP: begin
                u_r = int'(a) - int'(b);
                exp_psr[`PSR_C] = (u_r >= 0); // a >= b
            end
            OP_AND: u_r = int'(a & b);
            OP_ORA: u_r = int'(a | b);
            OP_EOR: u_r = int'(a ^ b);
            OP_PLP: begin
                exp_psr = b;
                exp_psr[`PSR_B] = 1'b0; // never stored
                exp_psr[`PSR_U] = 1'b0;
            end
            OP_CLC: exp_psr[`PSR_C] = 1'b0;
            OP_SEC: exp_psr[`PSR_C] = 1'b1;
            OP_CLI: exp_psr[`PSR_I] = 1'b0;
            OP_SEI: exp_psr[`PSR_I] = 1'b1;
            OP_CLD: exp_psr[`PSR_D] = 1'b0;
            OP_SED: exp_psr[`PSR_D] = 1'b1;
            OP_CLV: exp_psr[`PSR_V] = 1'b0;
            OP_SEV: exp_psr[`PSR_V] = 1'b1;
            default: u_r = int'(b); // lda
        endcase
        r = u_r[7:0];
        if (o inside {OP_ADC, OP_SBC, OP_CMP, OP_AND, OP_ORA, OP_EOR, OP_LDA}) begin
            exp_psr[`PSR_Z] = (r == 8'h00);
            exp_psr[`PSR_N] = r[7];
        end
    endtask

    `include "tb_status_tasks.svh"

    initial begin
        repeat (RUN_LIMIT) @(posedge clk);
        $display("error: run did not finish within %0d cycles", RUN_LIMIT);
        $display("FAIL: see errors above");
        $finish;
    end

    initial begin
        void'($urandom(32'he5d5_af20)); // single seed for the run
        nrst   = 1'b0;
        req    = 1'b0;
        brk    = 1'b0;
        op     = OP_ADC;
        opnd_a = 8'h00;
        opnd_b = 8'h00;
        repeat (3) @(posedge clk);
        #1;
        nrst = 1'b1;
        test_flags();
        test_adc();
        test_sub();
        test_logic();
        test_plp();
        test_backpressure();
        $display("summary: %0d tests, %0d checks, %0d errors", tests_run, checks, errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the status unit testbench with verilator
set -e
set -o pipefail
cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f status_exec.f --top-module tb_status_exec \
    -Mdir obj_dir -o tb_status_exec

./obj_dir/tb_status_exec | tee "$LOG"

if grep -q "FAIL: see errors above" "$LOG"; then
    echo "simulation failed, see $LOG"
    exit 1
fi
echo "simulation passed"

// File: status_exec.f
+incdir+verilog
+incdir+dv
verilog/status_pkg.sv
verilog/alu_core.sv
verilog/flag_decoder.sv
verilog/process_status_reg.sv
verilog/op_sequencer.sv
verilog/status_exec_top.sv
dv/tb_status_exec.sv

// File: verilog/alu_core.sv
`timescale 1ns/1ps
`default_nettype none

module alu_core
    import status_pkg::*;
(
    input  alu_fn_e    alu_fn,       // function select
    input  logic [7:0] a,            // accumulator side
    input  logic [7:0] b,            // memory side
    input  logic       invert_b,     // subtract and compare
    input  logic       carry_in,
    output logic [7:0] sum,
    output logic       carry_out,
    output logic       overflow_out
);

    logic [7:0] b_eff; // b after optional inversion
    logic [8:0] add_full;

    assign b_eff    = invert_b ? ~b : b;
    assign add_full = {1'b0, a} + {1'b0, b_eff} + {8'd0, carry_in};

    always_comb begin
        sum          = 8'd0;
        carry_out    = 1'b0; // logic ops leave carry low
        overflow_out = 1'b0; // also gives the zero source for clv
        case (alu_fn)
            ALU_ADD: begin
                sum       = add_full[7:0];
                carry_out = add_full[8];
                // operands agree in sign, result does not
                overflow_out = (a[7] == b_eff[7]) && (add_full[7] != a[7]);
            end
            ALU_AND: begin
                sum = a & b;
            end
            ALU_OR: begin
                sum = a | b;
            end
            ALU_EOR: begin
                sum = a ^ b;
            end
            ALU_PASS_B: begin
                sum = b; // lda, plp, flag ops
            end
            default: begin
                sum = 8'd0;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: verilog/flag_decoder.sv
`timescale 1ns/1ps
`default_nettype none
`include "status_defs.svh"

module flag_decoder
    import status_pkg::*;
(
    input  logic     clk,        // only for the opcode check
    input  exec_op_e op,
    input  logic     exec,       // one-cycle execute pulse
    input  logic     c_flag,     // current carry from the register
    output alu_fn_e  alu_fn,
    output logic     invert_b,
    output logic     carry_in,
    output logic     db_from_b,  // data bus takes operand b over alu sum
    output logic     db0_c,
    output logic     db1_z,
    output logic     db2_i,
    output logic     db3_d,
    output logic     db6_v,
    output logic     db7_n,
    output logic     manual_set,
    output logic     manual_c,
    output logic     manual_i,
    output logic     manual_d,
    output logic     carry_c,
    output logic     dball_z,
    output logic     overflow_v,
    output logic     rcl_v
);

    always_comb begin
        alu_fn     = ALU_PASS_B;
        invert_b   = 1'b0;
        carry_in   = 1'b0;
        db_from_b  = 1'b0;
        {db0_c, db1_z, db2_i, db3_d, db6_v, db7_n} = 6'b0;
        {manual_set, manual_c, manual_i, manual_d} = 4'b0;
        {carry_c, dball_z, overflow_v, rcl_v}      = 4'b0;
        if (exec) begin // nothing reaches the register outside execute
            case (op)
                OP_ADC, OP_SBC: begin
                    alu_fn     = ALU_ADD;
                    invert_b   = (op == OP_SBC); // a + ~b + c
                    carry_in   = c_flag;
                    carry_c    = 1'b1;
                    overflow_v = 1'b1;
                    dball_z    = 1'b1;
                    db7_n      = 1'b1;
                end
                OP_CMP: begin
                    alu_fn   = ALU_ADD;
                    invert_b = 1'b1;
                    carry_in = 1'b1; // plain a - b
                    carry_c  = 1'b1;
                    dball_z  = 1'b1;
                    db7_n    = 1'b1;
                end
                OP_AND: begin
                    alu_fn  = ALU_AND;
                    dball_z = 1'b1;
                    db7_n   = 1'b1;
                end
                OP_ORA: begin
                    alu_fn  = ALU_OR;
                    dball_z = 1'b1;
                    db7_n   = 1'b1;
                end
                OP_EOR: begin
                    alu_fn  = ALU_EOR;
                    dball_z = 1'b1;
                    db7_n   = 1'b1;
                end
                OP_LDA: begin
                    dball_z = 1'b1;
                    db7_n   = 1'b1;
                end
                OP_PLP: begin
                    db_from_b = 1'b1;
                    {db0_c, db1_z, db2_i, db3_d, db6_v, db7_n} = 6'b111111;
                end
                OP_CLC:  manual_c = 1'b1;
                OP_SEC:  {manual_set, manual_c} = 2'b11;
                OP_CLI:  manual_i = 1'b1;
                OP_SEI:  {manual_set, manual_i} = 2'b11;
                OP_CLD:  manual_d = 1'b1;
                OP_SED:  {manual_set, manual_d} = 2'b11;
                OP_CLV:  overflow_v = 1'b1; // pass_b leaves alu overflow low
                OP_SEV:  rcl_v = 1'b1;
                default: alu_fn = ALU_PASS_B;
            endcase
        end
    end

    // only defined opcodes may reach execute
    a_op_defined: assert property (@(posedge clk)
        exec |-> (op <= OP_SEV));

endmodule

`default_nettype wire

// File: verilog/op_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module op_sequencer
    import status_pkg::*;
(
    input  logic       clk,
    input  logic       nrst,
    input  logic       req,     // four-phase request
    input  exec_op_e   op,
    input  logic [7:0] opnd_a,
    input  logic [7:0] opnd_b,
    input  logic [7:0] sum,     // alu output
    output logic       ack,
    output logic       exec,    // one-cycle execute strobe
    output exec_op_e   op_q,
    output logic [7:0] a_q,
    output logic [7:0] b_q,
    output logic [7:0] result
);

    typedef enum logic [1:0] {
        S_IDLE = 2'd0,
        S_EXEC = 2'd1,
        S_HOLD = 2'd2
    } seq_state_e;

    seq_state_e state_q;
    logic       take;

    assign take = (state_q == S_IDLE) && req; // accept only after ack fell
    assign exec = (state_q == S_EXEC);

    always_ff @(posedge clk, negedge nrst) begin
        if (!nrst) begin
            state_q <= S_IDLE;
            ack     <= 1'b0;
            result  <= 8'd0;
        end else begin
            case (state_q)
                S_IDLE: if (req) state_q <= S_EXEC;
                S_EXEC: begin
                    result  <= sum; // psr updates on the same edge
                    state_q <= S_HOLD;
                end
                S_HOLD: begin
                    if (!ack) begin
                        ack <= 1'b1; // one cycle after the update
                    end else if (!req) begin
                        ack     <= 1'b0;
                        state_q <= S_IDLE;
                    end
                end
                default: state_q <= S_IDLE;
            endcase
        end
    end

    // operands held for the whole transfer
    always_ff @(posedge clk) begin
        if (take) begin
            op_q <= op;
            a_q  <= opnd_a;
            b_q  <= opnd_b;
        end
    end

    a_ack_no_exec: assert property (@(posedge clk) disable iff (!nrst) ack |-> !exec);

    // requester keeps req up until ack
    a_req_held: assert property (@(posedge clk) disable iff (!nrst)
        (state_q != S_IDLE && !ack) |-> req);

endmodule

`default_nettype wire

// File: verilog/process_status_reg.sv
`timescale 1ns/1ps
`default_nettype none
`include "status_defs.svh"

module process_status_reg
    import status_pkg::*;
(
    input  logic         clk,
    input  logic         nrst,
    input  logic [7:0]   db_in,       // data bus
    input  logic         manual_set,  // value for the manual enables
    input  logic         carry,       // alu carry
    input  logic         overflow,    // alu overflow
    input  logic         db0_c,
    input  logic         db1_z,
    input  logic         db2_i,
    input  logic         db3_d,
    input  logic         db6_v,
    input  logic         db7_n,
    input  logic         manual_c,
    input  logic         manual_i,
    input  logic         manual_d,
    input  logic         carry_c,     // c from alu
    input  logic         dball_z,     // z from whole bus
    input  logic         overflow_v,  // v from alu
    input  logic         rcl_v,       // force v high
    input  logic         break_set,
    output status_word_t psr_output
);

    logic [7:0] stat_q, stat_nxt;

    always_ff @(posedge clk, negedge nrst) begin
        if (!nrst) begin
            stat_q <= 8'd0;
        end else begin
            stat_q <= stat_nxt;
        end
    end

    // later sources win, bus < manual < alu < rcl
    always_comb begin
        stat_nxt = stat_q; // hold by default
        if (db0_c) stat_nxt[`PSR_C] = db_in[`PSR_C];
        if (db1_z) stat_nxt[`PSR_Z] = db_in[`PSR_Z];
        if (db2_i) stat_nxt[`PSR_I] = db_in[`PSR_I];
        if (db3_d) stat_nxt[`PSR_D] = db_in[`PSR_D];
        if (db6_v) stat_nxt[`PSR_V] = db_in[`PSR_V];
        if (db7_n) stat_nxt[`PSR_N] = db_in[`PSR_N];
        if (manual_c) stat_nxt[`PSR_C] = manual_set;
        if (manual_i) stat_nxt[`PSR_I] = manual_set;
        if (manual_d) stat_nxt[`PSR_D] = manual_set;
        if (carry_c) stat_nxt[`PSR_C] = carry;
        if (dball_z) stat_nxt[`PSR_Z] = ~|db_in; // zero detect on bus
        if (overflow_v) stat_nxt[`PSR_V] = overflow;
        if (rcl_v) stat_nxt[`PSR_V] = 1'b1;
        stat_nxt[`PSR_B] = 1'b0; // b and u never stored
        stat_nxt[`PSR_U] = 1'b0;
    end

    always_comb begin
        psr_output         = stat_q;
        psr_output[`PSR_B] = break_set; // break pin straight through
        psr_output[`PSR_U] = break_set;
    end

    // decoder must not select two carry sources at once
    a_one_carry_src: assert property (@(posedge clk) disable iff (!nrst)
        !(carry_c && db0_c));

endmodule

`default_nettype wire

// File: verilog/status_defs.svh
`ifndef STATUS_DEFS_SVH
`define STATUS_DEFS_SVH

// opcode field width, room for all supported ops
`define EXEC_OP_W 5

// status byte bit positions
`define PSR_C 0 // carry
`define PSR_Z 1 // zero
`define PSR_I 2 // irq disable
`define PSR_D 3 // decimal, stored only
`define PSR_B 4 // break, driven from brk pin
`define PSR_U 5 // unused, also follows brk
`define PSR_V 6 // overflow
`define PSR_N 7 // negative

// handshake wait limit in cycles
`define EXEC_ACK_TIMEOUT 20
`define EXEC_CYC_PER_OP 8 // cycle budget per op for run timeout
`define EXEC_TIMEOUT_BASE 100

`endif

// File: verilog/status_exec_top.sv
`timescale 1ns/1ps
`default_nettype none
`include "status_defs.svh"

module status_exec_top
    import status_pkg::*;
(
    input  logic         clk,
    input  logic         nrst,
    input  logic         req,
    input  exec_op_e     op,
    input  logic [7:0]   opnd_a,
    input  logic [7:0]   opnd_b,
    input  logic         brk,     // break pin onto psr bits 5:4
    output logic         ack,
    output logic [7:0]   result,
    output status_word_t psr
);

    exec_op_e   op_q;
    alu_fn_e    alu_fn;
    logic       exec;
    logic [7:0] a_q, b_q;
    logic [7:0] alu_sum;
    logic       alu_carry, alu_ovf;
    logic       invert_b, carry_in, db_from_b;
    logic       db0_c, db1_z, db2_i, db3_d, db6_v, db7_n;
    logic       manual_set, manual_c, manual_i, manual_d;
    logic       carry_c, dball_z, overflow_v, rcl_v;
    logic [7:0] db_bus;

    assign db_bus = db_from_b ? b_q : alu_sum; // plp reads the raw operand

    op_sequencer u_seq (
        .clk(clk), .nrst(nrst), .req(req), .op(op),
        .opnd_a(opnd_a), .opnd_b(opnd_b), .sum(alu_sum),
        .ack(ack), .exec(exec), .op_q(op_q),
        .a_q(a_q), .b_q(b_q), .result(result)
    );

    flag_decoder u_dec (
        .clk(clk), .op(op_q), .exec(exec), .c_flag(psr[`PSR_C]),
        .alu_fn(alu_fn), .invert_b(invert_b), .carry_in(carry_in), .db_from_b(db_from_b),
        .db0_c(db0_c), .db1_z(db1_z), .db2_i(db2_i), .db3_d(db3_d),
        .db6_v(db6_v), .db7_n(db7_n), .manual_set(manual_set),
        .manual_c(manual_c), .manual_i(manual_i), .manual_d(manual_d),
        .carry_c(carry_c), .dball_z(dball_z), .overflow_v(overflow_v), .rcl_v(rcl_v)
    );

    alu_core u_alu (
        .alu_fn(alu_fn), .a(a_q), .b(b_q), .invert_b(invert_b), .carry_in(carry_in),
        .sum(alu_sum), .carry_out(alu_carry), .overflow_out(alu_ovf)
    );

    process_status_reg u_psr (
        .clk(clk), .nrst(nrst), .db_in(db_bus), .manual_set(manual_set),
        .carry(alu_carry), .overflow(alu_ovf),
        .db0_c(db0_c), .db1_z(db1_z), .db2_i(db2_i), .db3_d(db3_d),
        .db6_v(db6_v), .db7_n(db7_n),
        .manual_c(manual_c), .manual_i(manual_i), .manual_d(manual_d),
        .carry_c(carry_c), .dball_z(dball_z), .overflow_v(overflow_v), .rcl_v(rcl_v),
        .break_set(brk), .psr_output(psr)
    );

endmodule

`default_nettype wire

// File: verilog/status_pkg.sv
`default_nettype none
`include "status_defs.svh"

package status_pkg;

    // operations accepted over the req/ack port
    typedef enum logic [`EXEC_OP_W-1:0] {
        OP_ADC = 5'd0,  // binary add with carry
        OP_SBC = 5'd1,  // binary subtract with borrow
        OP_CMP = 5'd2,  // compare, V untouched
        OP_AND = 5'd3,
        OP_ORA = 5'd4,
        OP_EOR = 5'd5,
        OP_LDA = 5'd6,  // N/Z from operand b
        OP_PLP = 5'd7,  // status from operand b
        OP_CLC = 5'd8,
        OP_SEC = 5'd9,
        OP_CLI = 5'd10,
        OP_SEI = 5'd11,
        OP_CLD = 5'd12,
        OP_SED = 5'd13,
        OP_CLV = 5'd14,
        OP_SEV = 5'd15  // set-overflow pin
    } exec_op_e;

    // alu function select
    typedef enum logic [2:0] {
        ALU_ADD    = 3'd0,
        ALU_AND    = 3'd1,
        ALU_OR     = 3'd2,
        ALU_EOR    = 3'd3,
        ALU_PASS_B = 3'd4
    } alu_fn_e;

    typedef logic [7:0] status_word_t; // NV-BDIZC byte

endpackage

`default_nettype wire
